// File: Bender.yml
package:
  name: event_counter

sources:
  # design, in compile order
  - files:
      - hdl/counterPkg.sv
      - hdl/PrefixAnd.sv
      - hdl/IncDecC.sv
      - hdl/countCore.sv
      - hdl/countCtrl.sv
      - hdl/eventCounter.sv

  # testbench, top module eventCounterTb
  - target: test
    files:
      - verification/eventCounterTb.sv

// File: eventCounter.f
hdl/counterPkg.sv
hdl/PrefixAnd.sv
hdl/IncDecC.sv
hdl/countCore.sv
hdl/countCtrl.sv
hdl/eventCounter.sv
verification/eventCounterTb.sv

// File: hdl/IncDecC.sv
`timescale 1ns/1ps
`default_nettype none

// increment or decrement by CI with carry out
// {CO,Z} = DEC ? A - CI : A + CI
module IncDecC #(
	parameter int width = 8,  // operand width
	parameter int speed = 0   // prefix structure, see PrefixAnd
) (
	input  logic [width-1:0] A,    // operand
	input  logic             CI,   // carry in, the step
	input  logic             DEC,  // 1 selects decrement
	output logic [width-1:0] Z,    // result
	output logic             CO    // carry or borrow out
);

	logic [width:0] propIn;   // carry in at bit 0, operand above it
	logic [width:0] propOut;  // prefix AND of propIn

	// decrement toggles up to the first one, so look for ones in ~A
	assign propIn = {A ^ {width{DEC}}, CI};

	PrefixAnd #(
		.width(width + 1),
		.speed(speed)
	) prefix (
		.PI(propIn),
		.PO(propOut)
	);

	// bit j flips when CI and every lower bit propagate
	assign Z  = A ^ propOut[width-1:0];
	assign CO = propOut[width];  // all bits propagated

endmodule

`default_nettype wire

// File: hdl/PrefixAnd.sv
`timescale 1ns/1ps
`default_nettype none

// running AND over PI from bit 0 upward
// PO[i] = PI[0] & PI[1] & ... & PI[i]
module PrefixAnd #(
	parameter int width = 8,  // number of bits
	parameter int speed = 0   // 0 serial, 1 Brent-Kung, 2 Sklansky
) (
	input  logic [width-1:0] PI,  // propagate in
	output logic [width-1:0] PO   // prefix AND out
);

	localparam int m = $clog2(width);  // tree depth in levels

	// ripple chain, width-1 gates deep
	if (speed == 0) begin : serialPrefix
		logic [width-1:0] chain;

		assign chain[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : bits
			assign chain[i] = chain[i-1] & PI[i];
		end
		assign PO = chain;
	end

	// Brent-Kung, up-sweep then down-sweep
	if (speed == 1) begin : brentKungPrefix
		localparam int depth = (m == 0) ? 0 : 2 * m - 1;  // total levels
		logic [width-1:0] stage [0:depth];

		assign stage[0] = PI;

		// up-sweep, bit 2^l-1 of every block ends up holding its block AND
		for (genvar l = 1; l <= m; l++) begin : upLevels
			for (genvar i = 0; i < width; i++) begin : bits
				if (((i + 1) % (2 ** l)) == 0) begin : node
					assign stage[l][i] = stage[l-1][i] & stage[l-1][i-2**(l-1)];
				end else begin : pass
					assign stage[l][i] = stage[l-1][i];
				end
			end
		end

		// down-sweep, fills in the midpoints from coarse to fine
		for (genvar l = m + 1; l <= depth; l++) begin : downLevels
			localparam int d = 2 * m - l;  // block size exponent at this level
			for (genvar i = 0; i < width; i++) begin : bits
				if ((i >= 2 ** d) && (((i + 1) % (2 ** d)) == 2 ** (d - 1))) begin : node
					// left neighbour is already a complete prefix
					assign stage[l][i] = stage[l-1][i] & stage[l-1][i-2**(d-1)];
				end else begin : pass
					assign stage[l][i] = stage[l-1][i];
				end
			end
		end

		assign PO = stage[depth];
	end

	// Sklansky, log depth with high fan-out
	if (speed == 2) begin : sklanskyPrefix
		logic [width-1:0] stage [0:m];

		assign stage[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : levels
			for (genvar i = 0; i < width; i++) begin : bits
				// upper half of a 2^l block takes the last bit of the lower half
				if (((i >> (l - 1)) % 2) == 1) begin : node
					localparam int src = ((i >> l) << l) + 2 ** (l - 1) - 1;
					assign stage[l][i] = stage[l-1][i] & stage[l-1][src];
				end else begin : pass
					assign stage[l][i] = stage[l-1][i];
				end
			end
		end

		assign PO = stage[m];
	end

	// other speed values fall back to the ripple chain
	if ((speed < 0) || (speed > 2)) begin : defaultPrefix
		logic [width-1:0] chain;

		assign chain[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : bits
			assign chain[i] = chain[i-1] & PI[i];
		end
		assign PO = chain;
	end

endmodule

`default_nettype wire

// File: hdl/countCore.sv
`timescale 1ns/1ps
`default_nettype none

// count register and step adder
// obeys the write enables, makes no decisions of its own
module countCore import counterPkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    stepDown,    // decrement select
	input  logic                    stepIn,      // carry in, 1 on up or down
	input  logic                    writeStep,   // take adder result
	input  logic                    writeLoad,   // take loadValue
	input  logic                    writeClear,  // zero the count
	input  logic [counterWidth-1:0] loadValue,
	output logic [counterWidth-1:0] count,
	output logic                    stepCarry    // carry out of current step
);

	logic [counterWidth-1:0] stepResult;  // count +/- stepIn

	// combinational from the register and the step controls
	IncDecC #(
		.width(counterWidth),
		.speed(prefixSpeed)
	) stepUnit (
		.A  (count),
		.CI (stepIn),
		.DEC(stepDown),
		.Z  (stepResult),
		.CO (stepCarry)
	);

	// clear wins over load, load over step
	always_ff @(posedge clk) begin
		if (reset || writeClear) begin
			count <= '0;
		end else if (writeLoad) begin
			count <= loadValue;
		end else if (writeStep) begin
			count <= stepResult;  // wrapped value on carry
		end
	end

endmodule

`default_nettype wire

// File: hdl/countCtrl.sv
`timescale 1ns/1ps
`default_nettype none

// opcode decode and overflow FSM
// enables are combinational, state and wrapped register with the count
module countCtrl import counterPkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   cmdValid,    // one cycle command strobe
	input  countOp cmdOp,
	input  logic   saturate,    // level, 1 saturate mode, 0 wrap mode
	input  logic   stepCarry,   // carry out from the core
	output logic   stepDown,
	output logic   stepIn,
	output logic   writeStep,
	output logic   writeLoad,
	output logic   writeClear,
	output logic   overflow,    // high while in stOverflow
	output logic   wrapped      // one cycle pulse after a wrapping step
);

	ctrlState state;
	ctrlState nextState;
	logic     isUp;
	logic     isDown;
	logic     stepAllowed;  // up or down while counting
	logic     satHit;       // saturating step would carry

	assign isUp   = cmdValid && (cmdOp == opUp);
	assign isDown = cmdValid && (cmdOp == opDown);

	// step controls depend only on the command, no loop through stepCarry
	assign stepDown = isDown;
	assign stepIn   = isUp || isDown;

	assign writeLoad  = cmdValid && (cmdOp == opLoad);
	assign writeClear = cmdValid && (cmdOp == opClear);

	assign stepAllowed = stepIn && (state == stCounting);  // frozen in overflow
	assign satHit      = stepAllowed && saturate && stepCarry;

	// saturated carry keeps the old count
	assign writeStep = stepAllowed && !satHit;

	always_comb begin
		nextState = state;
		if (writeLoad || writeClear) begin
			nextState = stCounting;  // only way out of overflow
		end else if (satHit) begin
			nextState = stOverflow;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= stCounting;
			wrapped <= 1'b0;
		end else begin
			state   <= nextState;
			wrapped <= stepAllowed && !saturate && stepCarry;  // wrap mode rollover
		end
	end

	assign overflow = (state == stOverflow);

endmodule

`default_nettype wire

// File: hdl/counterPkg.sv
`default_nettype none

// shared constants and types for the event counter
package counterPkg;

	// count word width
	localparam int counterWidth = 8;

	// prefix network choice for the step adder
	// 0 serial ripple, 1 Brent-Kung, 2 Sklansky
	localparam int prefixSpeed = 2;

	// command opcodes, sampled with cmdValid
	typedef enum logic [2:0] {
		opHold  = 3'd0,  // no change
		opLoad  = 3'd1,  // take loadValue
		opClear = 3'd2,  // zero the count
		opUp    = 3'd3,  // count + 1
		opDown  = 3'd4   // count - 1
	} countOp;

	// control FSM states
	typedef enum logic {
		stCounting = 1'b0,  // normal operation
		stOverflow = 1'b1   // sticky, left only by load or clear
	} ctrlState;

endpackage

`default_nettype wire

// File: hdl/eventCounter.sv
`timescale 1ns/1ps
`default_nettype none

// programmable up/down event counter, top level
module eventCounter import counterPkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    cmdValid,   // command strobe
	input  countOp                  cmdOp,
	input  logic [counterWidth-1:0] loadValue,  // used by opLoad
	input  logic                    saturate,   // mode level
	output logic [counterWidth-1:0] count,
	output logic                    overflow,
	output logic                    wrapped
);

	logic stepDown;
	logic stepIn;
	logic writeStep;
	logic writeLoad;
	logic writeClear;
	logic stepCarry;  // core back to control

	countCtrl ctrl (
		.clk       (clk),
		.reset     (reset),
		.cmdValid  (cmdValid),
		.cmdOp     (cmdOp),
		.saturate  (saturate),
		.stepCarry (stepCarry),
		.stepDown  (stepDown),
		.stepIn    (stepIn),
		.writeStep (writeStep),
		.writeLoad (writeLoad),
		.writeClear(writeClear),
		.overflow  (overflow),
		.wrapped   (wrapped)
	);

	countCore core (
		.clk       (clk),
		.reset     (reset),
		.stepDown  (stepDown),
		.stepIn    (stepIn),
		.writeStep (writeStep),
		.writeLoad (writeLoad),
		.writeClear(writeClear),
		.loadValue (loadValue),
		.count     (count),
		.stepCarry (stepCarry)
	);

endmodule

`default_nettype wire

// File: verification/eventCounterTb.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the event counter
// reference model steps on every rising edge and checks run on the falling edge
module eventCounterTb import counterPkg::*; ();

	localparam logic [counterWidth-1:0] allOnes = {counterWidth{1'b1}};

	// what the reference model tracks between edges
	typedef struct packed {
		logic [counterWidth-1:0] count;
		ctrlState                state;    // overflow level as a state
		logic                    wrapped;
	} modelResult;

	logic                    clk;
	logic                    reset;
	logic                    cmdValid;
	countOp                  cmdOp;
	logic [counterWidth-1:0] loadValue;
	logic                    saturate;
	logic [counterWidth-1:0] count;
	logic                    overflow;
	logic                    wrapped;

	modelResult expected;   // model outputs after the last edge
	int unsigned seed;

	eventCounter DUT (
		.clk      (clk),
		.reset    (reset),
		.cmdValid (cmdValid),
		.cmdOp    (cmdOp),
		.loadValue(loadValue),
		.saturate (saturate),
		.count    (count),
		.overflow (overflow),
		.wrapped  (wrapped)
	);

	always #50 clk = ~clk;  // 100 ns period

	// next model outputs from the command rules
	function automatic modelResult nextModel(input logic [counterWidth-1:0] curCount,
			input ctrlState curState, input logic valid, input countOp op,
			input logic [counterWidth-1:0] value, input logic sat);
		modelResult r;
		logic       carry;

		r.count   = curCount;
		r.state   = curState;
		r.wrapped = 1'b0;  // pulse only on the wrapping step
		if (valid) begin
			case (op)
				opLoad: begin
					r.count = value;
					r.state = stCounting;
				end
				opClear: begin
					r.count = '0;
					r.state = stCounting;
				end
				opUp, opDown: begin
					if (curState == stCounting) begin
						carry = (op == opUp) ? (curCount == allOnes) : (curCount == '0);
						if (carry && sat) begin
							r.state = stOverflow;  // count frozen
						end else begin
							r.count   = (op == opUp) ? curCount + 1'b1 : curCount - 1'b1;
							r.wrapped = carry;
						end
					end
				end
				default: ;  // hold
			endcase
		end
		return r;
	endfunction

	// biased toward the ends of the range so carries happen
	function automatic logic [counterWidth-1:0] pickLoadValue();
		case ($urandom % 4)
			0: return '0;
			1: return allOnes;
			2: return allOnes - 1'b1;
			default: return counterWidth'($urandom);
		endcase
	endfunction

	task automatic stopOnError(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compareCount(input string name, input logic [counterWidth-1:0] actual,
			input logic [counterWidth-1:0] want);
		if (actual !== want)
			stopOnError($sformatf("Error %s actual 0x%h expected 0x%h", name, actual, want));
	endtask

	task automatic compareFlag(input string name, input logic actual, input logic want);
		if (actual !== want)
			stopOnError($sformatf("Error %s actual 0x%h expected 0x%h", name, actual, want));
	endtask

	task automatic compareState(input string name, input ctrlState actual, input ctrlState want);
		if (actual !== want)
			stopOnError($sformatf("Error %s actual 0x%h expected 0x%h", name, actual, want));
	endtask

	// one command held for a single cycle unless the next call replaces it
	task automatic sendCmd(input countOp op, input logic [counterWidth-1:0] value);
		@(posedge clk);
		cmdValid  <= 1'b1;
		cmdOp     <= op;
		loadValue <= value;
	endtask

	task automatic sendIdle();
		@(posedge clk);
		cmdValid <= 1'b0;
		cmdOp    <= opHold;
	endtask

	task automatic setMode(input logic sat);
		@(posedge clk);
		cmdValid <= 1'b0;
		saturate <= sat;
	endtask

	// direct check of the outputs after the last command took effect
	task automatic checkOutputs(input logic [counterWidth-1:0] wantCount, input logic wantOvf,
			input logic wantWrap);
		@(negedge clk);
		compareCount("count", count, wantCount);
		compareFlag("overflow", overflow, wantOvf);
		compareFlag("wrapped", wrapped, wantWrap);
	endtask

	task automatic waitWrapPulse(input logic [counterWidth-1:0] wantCount);
		int n;

		sendIdle();
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!wrapped && n < 4);
		if (!wrapped)
			stopOnError("wrapped pulse did not appear after a carrying step in wrap mode");
		compareCount("count", count, wantCount);
		@(negedge clk);
		compareFlag("wrapped", wrapped, 1'b0);  // one cycle only
	endtask

	task automatic waitOverflow();
		int n;

		sendIdle();
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!overflow && n < 4);
		if (!overflow)
			stopOnError("overflow did not rise after a carrying step in saturate mode");
	endtask

	// reference model sees the same inputs as the DUT
	always @(posedge clk) begin
		if (reset)
			expected <= '{count: '0, state: stCounting, wrapped: 1'b0};
		else
			expected <= nextModel(expected.count, expected.state, cmdValid, cmdOp,
				loadValue, saturate);
	end

	// compare every cycle once outputs settle by the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			compareCount("count", count, expected.count);
			compareFlag("wrapped", wrapped, expected.wrapped);
			compareState("overflow", overflow ? stOverflow : stCounting, expected.state);
		end
	end

	// reset for 8 cycles
	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
	end

	initial begin
		int pick;
		int n;

		clk       = 1'b0;
		cmdValid  = 1'b0;
		cmdOp     = opHold;
		loadValue = '0;
		saturate  = 1'b0;
		seed      = 32'h8b68a642;
		void'($urandom(seed));  // only seeding

		n = 0;
		while (reset !== 1'b0 && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (reset !== 1'b0)
			stopOnError("reset was not released in time");

		checkOutputs('0, 1'b0, 1'b0);  // state out of reset

		// load then back to back steps with a hold in between
		sendCmd(opLoad, 8'h40);
		sendCmd(opUp, '0);
		sendCmd(opUp, '0);
		sendCmd(opHold, '0);
		sendCmd(opUp, '0);
		sendCmd(opDown, '0);
		sendIdle();
		checkOutputs(8'h42, 1'b0, 1'b0);  // 0x40 + 3 - 1

		// wrap mode in both directions
		setMode(1'b0);
		sendCmd(opLoad, allOnes);
		sendCmd(opUp, '0);
		waitWrapPulse('0);
		sendCmd(opLoad, '0);
		sendCmd(opDown, '0);
		waitWrapPulse(allOnes);

		// saturate mode with sticky overflow
		setMode(1'b1);
		sendCmd(opLoad, allOnes);
		sendCmd(opUp, '0);
		waitOverflow();
		compareCount("count", count, allOnes);
		sendCmd(opUp, '0);
		sendCmd(opDown, '0);
		sendCmd(opDown, '0);
		sendIdle();
		checkOutputs(allOnes, 1'b1, 1'b0);  // frozen
		sendCmd(opClear, '0);
		sendIdle();
		checkOutputs('0, 1'b0, 1'b0);

		// random commands and mode with mostly back to back strobes
		for (int i = 0; i < 2000; i++) begin
			pick = $urandom % 8;
			@(posedge clk);
			cmdValid  <= (pick != 0);
			cmdOp     <= countOp'($urandom % 5);
			loadValue <= pickLoadValue();
			if (($urandom % 64) == 0)
				saturate <= ~saturate;
		end
		sendIdle();
		repeat (3) @(negedge clk);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
